// ==== neuron_pkg.sv ====
package neuron_pkg;

	// operand, bias and result precision.
	localparam int OP_WIDTH  = 16;
	localparam int ACC_WIDTH = 40;
	localparam int OUT_WIDTH = 16;

	// default fixed-point position of operands and results.
	localparam int DEFAULT_FRAC_BITS = 8;

	typedef logic signed [OP_WIDTH-1:0] op_t;

	// sums stay in product scale.
	typedef logic signed [ACC_WIDTH-1:0] acc_t;

	typedef logic signed [OUT_WIDTH-1:0] out_t;

	// bit 0 square, bit 1 accumulate, bit 2 add operand.
	typedef logic [2:0] op_code_t;

	localparam op_code_t OP_MULT       = 3'd0;
	localparam op_code_t OP_SQUARE     = 3'd1;
	localparam op_code_t OP_MULT_ACC   = 3'd2;
	localparam op_code_t OP_SQUARE_ACC = 3'd3;
	localparam op_code_t OP_MULT_ADD   = 3'd4;
	localparam op_code_t OP_SQUARE_ADD = 3'd5;

endpackage

// ==== macc.sv ====
`timescale 1ns/1ps

module macc #(
	parameter int FRAC_BITS = neuron_pkg::DEFAULT_FRAC_BITS
) (
	input logic clk,
	input logic reset,
	input logic enable,
	input logic clear,
	input neuron_pkg::op_code_t op_code,
	input neuron_pkg::op_t op_0,
	input neuron_pkg::op_t op_1,
	input neuron_pkg::op_t op_add,
	output neuron_pkg::acc_t acc
);
	import neuron_pkg::*;

	// control delay lines, one tap per datapath register.
	logic [2:0] enable_pipe;
	logic [2:0] clear_pipe;
	op_code_t op_code_s1;
	op_code_t op_code_s2;
	op_code_t op_code_s3;

	// multiplier inputs and product pipeline.
	op_t mul_a;
	op_t mul_b;
	acc_t mult_q;
	acc_t product;

	// add operand follows the product down the pipe.
	op_t add_s1;
	op_t add_s2;
	op_t add_s3;
	acc_t bias_ext;
	acc_t acc_next;

	always_ff @(posedge clk) begin
		if (reset) begin
			enable_pipe <= '0;
			clear_pipe <= '0;
			op_code_s1 <= OP_MULT;
			op_code_s2 <= OP_MULT;
			op_code_s3 <= OP_MULT;
		end else begin
			enable_pipe <= {enable_pipe[1:0], enable};
			clear_pipe <= {clear_pipe[1:0], clear};
			op_code_s1 <= op_code;
			op_code_s2 <= op_code_s1;
			op_code_s3 <= op_code_s2;
		end
	end

	// stage 1.
	// a square feeds op_1 to both multiplier inputs.
	always_ff @(posedge clk) begin
		if (enable) begin
			mul_a <= op_code[0] ? op_1 : op_0;
			mul_b <= op_1;
			add_s1 <= op_add;
		end
	end

	// stage 2.
	// two product registers so the multiplier can be retimed.
	always_ff @(posedge clk) begin
		mult_q <= mul_a * mul_b;
		product <= mult_q;
		add_s2 <= add_s1;
		add_s3 <= add_s2;
	end

	// bias arrives in output scale.
	assign bias_ext = add_s3;

	always_comb begin
		case (op_code_s3)
			OP_MULT, OP_SQUARE: acc_next = product;
			OP_MULT_ACC, OP_SQUARE_ACC: acc_next = acc + product;
			OP_MULT_ADD, OP_SQUARE_ADD: acc_next = product + (bias_ext <<< FRAC_BITS);
			default: acc_next = acc;
		endcase
	end

	// stage 3.
	// clear wins over an enable of the same slot.
	always_ff @(posedge clk) begin
		if (reset || clear_pipe[2]) begin
			acc <= '0;
		end else if (enable_pipe[2]) begin
			acc <= acc_next;
		end
	end

endmodule

// ==== vector_sequencer.sv ====
`timescale 1ns/1ps

module vector_sequencer (
	input logic clk,
	input logic reset,
	input logic in_valid,
	input logic in_first,
	input logic in_last,
	input logic square_mode,
	input logic flush,
	output logic enable,
	output logic clear,
	output neuron_pkg::op_code_t op_code,
	output logic capture
);
	import neuron_pkg::*;

	typedef enum logic {
		ST_IDLE,
		ST_ACCUM
	} state_t;

	state_t state;
	logic starts_vector;
	logic last_accepted;

	// one tag per cycle of macc latency.
	logic [2:0] last_pipe;

	// an element seen in idle opens a vector even without in_first.
	assign starts_vector = in_first || (state == ST_IDLE);

	assign last_accepted = in_valid && in_last && !flush;

	// an element on the flush cycle is dropped.
	assign enable = in_valid && !flush;
	assign clear = flush;

	// first element loads the bias, later ones accumulate.
	always_comb begin
		if (square_mode) begin
			op_code = starts_vector ? OP_SQUARE_ADD : OP_SQUARE_ACC;
		end else begin
			op_code = starts_vector ? OP_MULT_ADD : OP_MULT_ACC;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= ST_IDLE;
		end else if (flush) begin
			state <= ST_IDLE;
		end else if (in_valid) begin
			state <= in_last ? ST_IDLE : ST_ACCUM;
		end
	end

	// capture lands one cycle after the final sum settles in acc.
	// a flush drops every tag still on its way.
	always_ff @(posedge clk) begin
		if (reset || flush) begin
			last_pipe <= '0;
			capture <= 1'b0;
		end else begin
			last_pipe <= {last_pipe[1:0], last_accepted};
			capture <= last_pipe[2];
		end
	end

endmodule

// ==== output_activation.sv ====
`timescale 1ns/1ps

module output_activation #(
	parameter int LANES = 4,
	parameter int FRAC_BITS = neuron_pkg::DEFAULT_FRAC_BITS
) (
	input logic clk,
	input logic reset,
	input logic capture,
	input logic relu_en,
	input logic [LANES*neuron_pkg::ACC_WIDTH-1:0] acc_lanes,
	output logic [LANES*neuron_pkg::OUT_WIDTH-1:0] results,
	output logic result_valid
);
	import neuron_pkg::*;

	// out_t limits widened to accumulator width.
	localparam acc_t SAT_MAX = {{(ACC_WIDTH-OUT_WIDTH+1){1'b0}}, {(OUT_WIDTH-1){1'b1}}};
	localparam acc_t SAT_MIN = {{(ACC_WIDTH-OUT_WIDTH+1){1'b1}}, {(OUT_WIDTH-1){1'b0}}};

	for (genvar i = 0; i < LANES; i++) begin : g_lane
		acc_t sum;
		acc_t scaled;
		acc_t rect;
		out_t sat;
		out_t res_q;

		assign sum = acc_lanes[i*ACC_WIDTH +: ACC_WIDTH];

		// back to output scale.
		assign scaled = sum >>> FRAC_BITS;
		assign rect = (relu_en && scaled < 0) ? '0 : scaled;

		always_comb begin
			if (rect > SAT_MAX) begin
				sat = SAT_MAX[OUT_WIDTH-1:0];
			end else if (rect < SAT_MIN) begin
				sat = SAT_MIN[OUT_WIDTH-1:0];
			end else begin
				sat = rect[OUT_WIDTH-1:0];
			end
		end

		// held until the next capture.
		always_ff @(posedge clk) begin
			if (reset) begin
				res_q <= '0;
			end else if (capture) begin
				res_q <= sat;
			end
		end

		assign results[i*OUT_WIDTH +: OUT_WIDTH] = res_q;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			result_valid <= 1'b0;
		end else begin
			result_valid <= capture;
		end
	end

endmodule

// ==== neuron_engine.sv ====
`timescale 1ns/1ps

module neuron_engine #(
	parameter int LANES = 4,
	parameter int FRAC_BITS = neuron_pkg::DEFAULT_FRAC_BITS
) (
	input logic clk,
	input logic reset,
	input logic in_valid,
	input logic in_first,
	input logic in_last,
	input logic square_mode,
	input logic relu_en,
	input logic flush,
	input neuron_pkg::op_t act,
	input logic [LANES*neuron_pkg::OP_WIDTH-1:0] weights,
	input logic [LANES*neuron_pkg::OP_WIDTH-1:0] biases,
	output logic result_valid,
	output logic [LANES*neuron_pkg::OUT_WIDTH-1:0] results
);
	import neuron_pkg::*;

	// shared by every lane.
	logic lane_enable;
	logic lane_clear;
	op_code_t lane_op_code;
	logic capture;

	logic [LANES*ACC_WIDTH-1:0] acc_lanes;

	vector_sequencer i_seq (
		.clk(clk),
		.reset(reset),
		.in_valid(in_valid),
		.in_first(in_first),
		.in_last(in_last),
		.square_mode(square_mode),
		.flush(flush),
		.enable(lane_enable),
		.clear(lane_clear),
		.op_code(lane_op_code),
		.capture(capture)
	);

	for (genvar i = 0; i < LANES; i++) begin : g_lane
		op_t weight;
		op_t bias;
		op_t op_0;
		acc_t lane_acc;

		assign weight = weights[i*OP_WIDTH +: OP_WIDTH];
		assign bias = biases[i*OP_WIDTH +: OP_WIDTH];

		// act is ignored when squaring weights.
		assign op_0 = square_mode ? weight : act;

		macc #(
			.FRAC_BITS(FRAC_BITS)
		) i_macc (
			.clk(clk),
			.reset(reset),
			.enable(lane_enable),
			.clear(lane_clear),
			.op_code(lane_op_code),
			.op_0(op_0),
			.op_1(weight),
			.op_add(bias),
			.acc(lane_acc)
		);

		assign acc_lanes[i*ACC_WIDTH +: ACC_WIDTH] = lane_acc;
	end

	output_activation #(
		.LANES(LANES),
		.FRAC_BITS(FRAC_BITS)
	) i_act (
		.clk(clk),
		.reset(reset),
		.capture(capture),
		.relu_en(relu_en),
		.acc_lanes(acc_lanes),
		.results(results),
		.result_valid(result_valid)
	);

endmodule

// ==== neuron_engine_checker.sv ====
`timescale 1ns/1ps

module neuron_engine_checker #(
	parameter int LANES = 4
) (
	input logic clk,
	input logic reset,
	input logic in_valid,
	input logic in_last,
	input logic flush,
	input logic result_valid,
	input logic [LANES*neuron_pkg::OUT_WIDTH-1:0] results
);
	logic last_taken;

	assign last_taken = in_valid && in_last && !flush;

	// a surviving last element comes out 4 cycles later.
	a_result_latency: assert property (@(posedge clk) disable iff (reset)
		($past(last_taken, 5) && !$past(flush, 4) && !$past(flush, 3) && !$past(flush, 2))
		|-> result_valid)
		else $error("result_valid did not follow a last element by 4 cycles");

	// every pulse needs its own last element.
	a_result_source: assert property (@(posedge clk) disable iff (reset)
		result_valid |-> $past(last_taken, 5))
		else $error("result_valid with no matching last element");

	a_reset_clears: assert property (@(posedge clk)
		reset |=> (!result_valid && results == '0))
		else $error("outputs not cleared by reset");

endmodule

bind neuron_engine neuron_engine_checker #(
	.LANES(LANES)
) i_checker (
	.clk(clk),
	.reset(reset),
	.in_valid(in_valid),
	.in_last(in_last),
	.flush(flush),
	.result_valid(result_valid),
	.results(results)
);

// ==== tb_neuron_engine.sv ====
`timescale 1ns/1ps

module tb_neuron_engine;
	import neuron_pkg::*;

	localparam int LANES = 4;
	localparam int FRAC_BITS = DEFAULT_FRAC_BITS;
	localparam int MAX_LEN = 8;
	localparam int TIMEOUT_CYCLES = 100;
	localparam int RESULT_LATENCY = 4;

	logic clk;
	logic reset;
	logic in_valid;
	logic in_first;
	logic in_last;
	logic square_mode;
	logic relu_en;
	logic flush;
	op_t act;
	logic [LANES*OP_WIDTH-1:0] weights;
	logic [LANES*OP_WIDTH-1:0] biases;
	logic result_valid;
	logic [LANES*OUT_WIDTH-1:0] results;

	// vector being built by the current test.
	op_t elem_act [MAX_LEN];
	op_t elem_w [MAX_LEN][LANES];
	op_t vec_bias [LANES];

	// expected results in output order.
	logic [LANES*OUT_WIDTH-1:0] exp_q [$];
	string name_q [$];
	logic [LANES*OUT_WIDTH-1:0] mon_exp;
	string mon_name;
	logic [31:0] lfsr_state;

	neuron_engine #(
		.LANES(LANES),
		.FRAC_BITS(FRAC_BITS)
	) i_dut (
		.clk(clk),
		.reset(reset),
		.in_valid(in_valid),
		.in_first(in_first),
		.in_last(in_last),
		.square_mode(square_mode),
		.relu_en(relu_en),
		.flush(flush),
		.act(act),
		.weights(weights),
		.biases(biases),
		.result_valid(result_valid),
		.results(results)
	);

	always #50 clk = ~clk;

	task automatic stop_sim();
		$display("sim failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_value(input string name, input longint expected, input longint actual);
		if (expected != actual) begin
			$display("Error: %s expected %0d actual %0d", name, expected, actual);
			stop_sim();
		end
	endtask

	// galois form of x^32 + x^22 + x^2 + x + 1.
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	function automatic longint take_bits(input int n);
		longint value;
		value = 0;
		for (int i = 0; i < n; i++) begin
			value = (value << 1) | longint'(lfsr_state[0]);
			lfsr_state = lfsr_next(lfsr_state);
		end
		return value;
	endfunction

	// signed value of n random bits.
	function automatic op_t rand_op(input int n);
		longint raw;
		raw = take_bits(n);
		if (raw >= (longint'(1) << (n - 1))) begin
			raw = raw - (longint'(1) << n);
		end
		return op_t'(raw);
	endfunction

	// bias in output scale plus full-precision products, then rescale.
	function automatic out_t model_lane(input int len, input bit sq, input bit relu, input int l);
		longint sum;
		longint scaled;
		longint max_out;
		longint min_out;
		max_out = (longint'(1) << (OUT_WIDTH - 1)) - 1;
		min_out = -(longint'(1) << (OUT_WIDTH - 1));
		sum = longint'(vec_bias[l]) * (longint'(1) << FRAC_BITS);
		for (int e = 0; e < len; e++) begin
			if (sq) begin
				sum += longint'(elem_w[e][l]) * longint'(elem_w[e][l]);
			end else begin
				sum += longint'(elem_act[e]) * longint'(elem_w[e][l]);
			end
		end
		scaled = sum >>> FRAC_BITS;
		if (relu && scaled < 0) begin
			scaled = 0;
		end
		if (scaled > max_out) begin
			scaled = max_out;
		end else if (scaled < min_out) begin
			scaled = min_out;
		end
		return out_t'(scaled);
	endfunction

	function automatic void fill_random(input int len);
		for (int e = 0; e < len; e++) begin
			elem_act[e] = rand_op(12);
			for (int l = 0; l < LANES; l++) begin
				elem_w[e][l] = rand_op(12);
			end
		end
		for (int l = 0; l < LANES; l++) begin
			vec_bias[l] = rand_op(12);
		end
	endfunction

	// odd lanes get the negated weight.
	function automatic void fill_alternating(input int len, input op_t a, input op_t w, input op_t b);
		for (int e = 0; e < len; e++) begin
			elem_act[e] = a;
			for (int l = 0; l < LANES; l++) begin
				elem_w[e][l] = (l % 2 == 1) ? -w : w;
			end
		end
		for (int l = 0; l < LANES; l++) begin
			vec_bias[l] = b;
		end
	endfunction

	task automatic drive_element(input int e, input bit is_first, input bit is_last,
		input bit sq, input bit relu);
		@(posedge clk);
		in_valid <= 1'b1;
		in_first <= is_first;
		in_last <= is_last;
		square_mode <= sq;
		relu_en <= relu;
		act <= elem_act[e];
		// later elements carry junk biases that must be ignored.
		for (int l = 0; l < LANES; l++) begin
			weights[l*OP_WIDTH +: OP_WIDTH] <= elem_w[e][l];
			biases[l*OP_WIDTH +: OP_WIDTH] <= is_first ? vec_bias[l] : ~vec_bias[l];
		end
	endtask

	task automatic send_vector(input string name, input int len, input bit sq, input bit relu);
		logic [LANES*OUT_WIDTH-1:0] word;
		for (int l = 0; l < LANES; l++) begin
			word[l*OUT_WIDTH +: OUT_WIDTH] = model_lane(len, sq, relu, l);
		end
		exp_q.push_back(word);
		name_q.push_back(name);
		for (int e = 0; e < len; e++) begin
			drive_element(e, e == 0, e == len - 1, sq, relu);
		end
	endtask

	task automatic end_stream();
		@(posedge clk);
		in_valid <= 1'b0;
		in_first <= 1'b0;
		in_last <= 1'b0;
		flush <= 1'b0;
	endtask

	task automatic wait_latency(input string name);
		int cycles;
		cycles = 0;
		// counts edges after the one that took the last element.
		@(negedge clk);
		while (result_valid !== 1'b1 && cycles < TIMEOUT_CYCLES) begin
			@(negedge clk);
			cycles++;
		end
		if (result_valid !== 1'b1) begin
			$display("timed out waiting for result_valid in %s", name);
			stop_sim();
		end else begin
			check_value(name, RESULT_LATENCY, cycles);
		end
	endtask

	task automatic wait_drained(input string name);
		int cycles;
		cycles = 0;
		while (exp_q.size() != 0 && cycles < TIMEOUT_CYCLES) begin
			@(negedge clk);
			cycles++;
		end
		if (exp_q.size() != 0) begin
			$display("timed out with %0d results missing in %s", exp_q.size(), name);
			stop_sim();
		end
	endtask

	// results are compared lane by lane as they come out.
	always @(negedge clk) begin
		if (!reset && result_valid === 1'b1) begin
			if (exp_q.size() == 0) begin
				$display("result_valid pulsed with no vector pending");
				stop_sim();
			end else begin
				mon_exp = exp_q.pop_front();
				mon_name = name_q.pop_front();
				for (int l = 0; l < LANES; l++) begin
					check_value($sformatf("%s lane %0d", mon_name, l),
						out_t'(mon_exp[l*OUT_WIDTH +: OUT_WIDTH]),
						out_t'(results[l*OUT_WIDTH +: OUT_WIDTH]));
				end
			end
		end
	end

	task automatic test_dot_product();
		for (int e = 0; e < 5; e++) begin
			elem_act[e] = op_t'((e + 1) * 96 - 200);
			for (int l = 0; l < LANES; l++) begin
				elem_w[e][l] = op_t'((l + 1) * 50 - e * 70);
			end
		end
		for (int l = 0; l < LANES; l++) begin
			vec_bias[l] = op_t'(l * 200 - 250);
		end
		send_vector("dot_product", 5, 1'b0, 1'b0);
		end_stream();
		wait_latency("dot_product latency");
		wait_drained("dot_product");
	endtask

	task automatic test_square_mode();
		fill_random(4);
		send_vector("square_mode", 4, 1'b1, 1'b0);
		end_stream();
		wait_drained("square_mode");
	endtask

	task automatic test_saturation();
		fill_alternating(4, 16'sd32767, 16'sd30000, 16'sd0);
		send_vector("saturation", 4, 1'b0, 1'b0);
		end_stream();
		wait_drained("saturation");
		send_vector("saturation relu", 4, 1'b0, 1'b1);
		end_stream();
		wait_drained("saturation relu");
		// moderate sums pass relu unchanged when positive.
		fill_alternating(3, 16'sd256, 16'sd300, 16'sd20);
		send_vector("relu pass", 3, 1'b0, 1'b1);
		end_stream();
		wait_drained("relu pass");
	endtask

	task automatic test_back_to_back();
		fill_random(1);
		send_vector("back_to_back 1", 1, 1'b0, 1'b0);
		fill_random(3);
		send_vector("back_to_back 2", 3, 1'b1, 1'b0);
		fill_random(2);
		send_vector("back_to_back 3", 2, 1'b0, 1'b0);
		end_stream();
		wait_drained("back_to_back");
	endtask

	task automatic test_flush();
		fill_random(4);
		drive_element(0, 1'b1, 1'b0, 1'b0, 1'b0);
		drive_element(1, 1'b0, 1'b0, 1'b0, 1'b0);
		// the flush lands while this last element is still in the pipe.
		drive_element(2, 1'b0, 1'b1, 1'b0, 1'b0);
		@(posedge clk);
		in_valid <= 1'b0;
		in_first <= 1'b0;
		in_last <= 1'b0;
		flush <= 1'b1;
		@(posedge clk);
		flush <= 1'b0;
		fill_random(2);
		send_vector("flush", 2, 1'b0, 1'b0);
		end_stream();
		wait_drained("flush");
		repeat (8) @(posedge clk);
	endtask

	task automatic test_random();
		int len;
		bit sq;
		for (int i = 0; i < 20; i++) begin
			len = int'(take_bits(3)) + 1;
			sq = take_bits(1) != 0;
			fill_random(len);
			send_vector($sformatf("random %0d", i), len, sq, 1'b0);
		end
		end_stream();
		wait_drained("random");
	endtask

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		in_valid = 1'b0;
		in_first = 1'b0;
		in_last = 1'b0;
		square_mode = 1'b0;
		relu_en = 1'b0;
		flush = 1'b0;
		act = '0;
		weights = '0;
		biases = '0;
		lfsr_state = 32'hf48c;
		repeat (3) @(posedge clk);
		reset <= 1'b0;
		test_dot_product();
		test_square_mode();
		test_saturation();
		test_back_to_back();
		test_flush();
		test_random();
		$display("sim passed");
		$finish;
	end

endmodule

// ==== neuron_engine.f ====
neuron_pkg.sv
macc.sv
vector_sequencer.sv
output_activation.sv
neuron_engine.sv
neuron_engine_checker.sv
tb_neuron_engine.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP := tb_neuron_engine
FILELIST := neuron_engine.f
BUILD_DIR := obj_dir
LOG := sim.log
PASS_MSG := sim passed
VFLAGS := --binary --timing --assert -Wno-fatal --Mdir $(BUILD_DIR)
LINT_FLAGS := --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
